// File: Bender.yml
package:
  name: cv_controller

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cv_ctrl_pkg.sv
      - src/cv_input_stage.sv
      - src/cv_keypad_encoder.sv
      - src/cv_spinner.sv
      - src/cv_port_mux.sv
      - src/cv_controller_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_cv_controller.sv

// File: include/cv_ctrl_consts.svh
`ifndef CV_CTRL_CONSTS_SVH
`define CV_CTRL_CONSTS_SVH

// Host joystick word width
`define CV_JOY_BITS 8

// PS/2 key flags and PS/2 joystick flags share one width
`define CV_KEY_BITS 16

// ---------------------------------------------------------------------------
// Host joystick bit positions, active high
// ---------------------------------------------------------------------------
`define CV_JOY_RIGHT 0
`define CV_JOY_LEFT  1
`define CV_JOY_DOWN  2
`define CV_JOY_UP    3
`define CV_JOY_FIRE1 4
`define CV_JOY_FIRE2 5

// ---------------------------------------------------------------------------
// PS/2 joystick flag bit positions, active high
// ---------------------------------------------------------------------------
`define CV_PS2J_UP    0
`define CV_PS2J_DOWN  1
`define CV_PS2J_LEFT  2
`define CV_PS2J_RIGHT 3
`define CV_PS2J_FIRE  4

// Spinner tick period is 2**CV_SPIN_DIV_BITS cycles
`define CV_SPIN_DIV_BITS 16

`define CV_PORTS 2

`endif

// File: src/cv_controller_top.sv
`include "cv_ctrl_consts.svh"

module cv_controller_top #(
    parameter int spin_div_bits = `CV_SPIN_DIV_BITS
) (
    input  logic                                     clk_sys,
    input  logic                                     reset,
    input  logic [`CV_JOY_BITS-1:0]                  joy0_i,
    input  logic [`CV_JOY_BITS-1:0]                  joy1_i,
    input  logic [`CV_KEY_BITS-1:0]                  ps2_keys_i,
    input  logic [`CV_KEY_BITS-1:0]                  ps2_joy_i,
    input  logic [`CV_PORTS-1:0]                     sel_p5_i,
    input  logic [`CV_PORTS-1:0]                     sel_p8_i,
    input  logic                                     joyswap_i,
    input  logic                                     spinner_en_i,
    output cv_ctrl_pkg::ctrl_pins_t [`CV_PORTS-1:0]  ports_o
);
    import cv_ctrl_pkg::*;

    port_in_t [`CV_PORTS-1:0] port_in;
    logic [`CV_KEY_BITS-1:0]  keys;
    logic [`CV_KEY_BITS-1:0]  ps2_joy;
    logic                     spinner_en;
    logic                     spinner_tick;
    keypad_t                  keypad;

    // -----------------------------------------------------------------------
    // Input side and shared keypad
    // -----------------------------------------------------------------------
    cv_input_stage #(
        .spin_div_bits (spin_div_bits)
    ) i_input_stage (
        .clk_sys_i      (clk_sys),
        .reset_i        (reset),
        .joy0_i         (joy0_i),
        .joy1_i         (joy1_i),
        .ps2_keys_i     (ps2_keys_i),
        .ps2_joy_i      (ps2_joy_i),
        .sel_p5_i       (sel_p5_i),
        .sel_p8_i       (sel_p8_i),
        .joyswap_i      (joyswap_i),
        .spinner_en_i   (spinner_en_i),
        .port_in_o      (port_in),
        .keys_o         (keys),
        .ps2_joy_o      (ps2_joy),
        .spinner_en_o   (spinner_en),
        .spinner_tick_o (spinner_tick)
    );

    // Both ports read the same keyboard
    cv_keypad_encoder i_keypad_encoder (
        .keys_i   (keys),
        .keypad_o (keypad)
    );

    // -----------------------------------------------------------------------
    // Per-port spinner and pin multiplexer
    // -----------------------------------------------------------------------
    for (genvar g = 0; g < `CV_PORTS; g++) begin : g_port
        logic [3:0] p1_4;

        cv_spinner i_spinner (
            .clk_sys_i      (clk_sys),
            .reset_i        (reset),
            .port_in_i      (port_in[g]),
            .spinner_en_i   (spinner_en),
            .spinner_tick_i (spinner_tick),
            .p7_o           (ports_o[g].p7),
            .p9_o           (ports_o[g].p9)
        );

        cv_port_mux i_port_mux (
            .port_in_i (port_in[g]),
            .keypad_i  (keypad),
            .ps2_joy_i (ps2_joy),
            .p1_4_o    (p1_4),
            .p6_o      (ports_o[g].p6)
        );

        assign ports_o[g].p1 = p1_4[3];
        assign ports_o[g].p2 = p1_4[2];
        assign ports_o[g].p3 = p1_4[1];
        assign ports_o[g].p4 = p1_4[0];
    end

endmodule

// File: src/cv_ctrl_pkg.sv
`include "cv_ctrl_consts.svh"

package cv_ctrl_pkg;

    // -----------------------------------------------------------------------
    // Keypad keys, in the order of the pin pattern table
    // -----------------------------------------------------------------------
    typedef enum logic [3:0] {
        KEY_0        = 4'd0,
        KEY_1        = 4'd1,
        KEY_2        = 4'd2,
        KEY_3        = 4'd3,
        KEY_4        = 4'd4,
        KEY_5        = 4'd5,
        KEY_6        = 4'd6,
        KEY_7        = 4'd7,
        KEY_8        = 4'd8,
        KEY_9        = 4'd9,
        KEY_ASTERISK = 4'd10,
        KEY_NUMBER   = 4'd11,
        KEY_NONE     = 4'd12
    } cv_key_e;

    // Port mode as selected by pins 5 and 8
    typedef enum logic [1:0] {
        MODE_IDLE     = 2'd0,
        MODE_KEYPAD   = 2'd1,
        MODE_JOYSTICK = 2'd2
    } port_mode_e;

    // Sampled inputs of one port, joystick already swapped
    typedef struct packed {
        logic [`CV_JOY_BITS-1:0] joy;
        logic                    sel_p5;
        logic                    sel_p8;
    } port_in_t;

    // Active-low pin levels seen by the console
    typedef struct packed {
        logic p1;
        logic p2;
        logic p3;
        logic p4;
        logic p6;
        logic p7;
        logic p9;
    } ctrl_pins_t;

    // Bit 3 of p1_4 is pin 1, bit 0 is pin 4
    typedef struct packed {
        logic [3:0] p1_4;
        logic       p6;
    } keypad_t;

endpackage

// File: src/cv_input_stage.sv
`include "cv_ctrl_consts.svh"

module cv_input_stage #(
    parameter int spin_div_bits = `CV_SPIN_DIV_BITS
) (
    input  logic                                   clk_sys_i,
    input  logic                                   reset_i,
    input  logic [`CV_JOY_BITS-1:0]                joy0_i,
    input  logic [`CV_JOY_BITS-1:0]                joy1_i,
    input  logic [`CV_KEY_BITS-1:0]                ps2_keys_i,
    input  logic [`CV_KEY_BITS-1:0]                ps2_joy_i,
    input  logic [`CV_PORTS-1:0]                   sel_p5_i,
    input  logic [`CV_PORTS-1:0]                   sel_p8_i,
    input  logic                                   joyswap_i,
    input  logic                                   spinner_en_i,
    output cv_ctrl_pkg::port_in_t [`CV_PORTS-1:0]  port_in_o,
    output logic [`CV_KEY_BITS-1:0]                keys_o,
    output logic [`CV_KEY_BITS-1:0]                ps2_joy_o,
    output logic                                   spinner_en_o,
    output logic                                   spinner_tick_o
);
    import cv_ctrl_pkg::*;

    port_in_t [`CV_PORTS-1:0] port_in_d;
    logic [spin_div_bits-1:0] tick_cnt;

    // Select pins pass straight through, joysticks may be crossed over
    always_comb begin
        for (int p = 0; p < `CV_PORTS; p++) begin
            port_in_d[p].sel_p5 = sel_p5_i[p];
            port_in_d[p].sel_p8 = sel_p8_i[p];
        end
        port_in_d[0].joy = joyswap_i ? joy1_i : joy0_i;
        port_in_d[1].joy = joyswap_i ? joy0_i : joy1_i;
    end

    // -----------------------------------------------------------------------
    // Input registers
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            // Both selects high means idle, so every pin reads high
            for (int p = 0; p < `CV_PORTS; p++) begin
                port_in_o[p].joy    <= '0;
                port_in_o[p].sel_p5 <= 1'b1;
                port_in_o[p].sel_p8 <= 1'b1;
            end
            keys_o       <= '0;
            ps2_joy_o    <= '0;
            spinner_en_o <= 1'b0;
        end else begin
            port_in_o    <= port_in_d;
            keys_o       <= ps2_keys_i;
            ps2_joy_o    <= ps2_joy_i;
            spinner_en_o <= spinner_en_i;
        end
    end

    // Free-running divider, tick follows each pass through zero
    always_ff @(posedge clk_sys_i) begin
        if (reset_i) begin
            tick_cnt       <= '0;
            spinner_tick_o <= 1'b0;
        end else begin
            tick_cnt       <= tick_cnt + 1'b1;
            spinner_tick_o <= (tick_cnt == '0);
        end
    end

endmodule

// File: src/cv_keypad_encoder.sv
`include "cv_ctrl_consts.svh"

module cv_keypad_encoder (
    input  logic [`CV_KEY_BITS-1:0] keys_i,
    output cv_ctrl_pkg::keypad_t    keypad_o
);
    import cv_ctrl_pkg::*;

    cv_key_e key;

    // -----------------------------------------------------------------------
    // Priority pick, first pressed key in scan order wins
    // -----------------------------------------------------------------------
    always_comb begin
        if (keys_i[13]) begin
            key = KEY_1;
        end else if (keys_i[7]) begin
            key = KEY_2;
        end else if (keys_i[12]) begin
            key = KEY_3;
        end else if (keys_i[2]) begin
            key = KEY_4;
        end else if (keys_i[3]) begin
            key = KEY_5;
        end else if (keys_i[14]) begin
            key = KEY_6;
        end else if (keys_i[5]) begin
            key = KEY_7;
        end else if (keys_i[1]) begin
            key = KEY_8;
        end else if (keys_i[11]) begin
            key = KEY_9;
        end else if (keys_i[10]) begin
            key = KEY_0;
        end else if (keys_i[9]) begin
            key = KEY_ASTERISK;
        end else if (keys_i[6]) begin
            key = KEY_NUMBER;
        end else begin
            key = KEY_NONE;
        end
    end

    // Key to pin pattern, written as pins 1 to 4
    always_comb begin
        case (key)
            KEY_0:        keypad_o.p1_4 = 4'b0011;
            KEY_1:        keypad_o.p1_4 = 4'b1110;
            KEY_2:        keypad_o.p1_4 = 4'b1101;
            KEY_3:        keypad_o.p1_4 = 4'b0110;
            KEY_4:        keypad_o.p1_4 = 4'b0001;
            KEY_5:        keypad_o.p1_4 = 4'b1001;
            KEY_6:        keypad_o.p1_4 = 4'b0111;
            KEY_7:        keypad_o.p1_4 = 4'b1100;
            KEY_8:        keypad_o.p1_4 = 4'b1000;
            KEY_9:        keypad_o.p1_4 = 4'b1011;
            KEY_ASTERISK: keypad_o.p1_4 = 4'b1010;
            KEY_NUMBER:   keypad_o.p1_4 = 4'b0101;
            default:      keypad_o.p1_4 = 4'b1111;
        endcase
    end

    // Second fire button from the keyboard
    assign keypad_o.p6 = ~keys_i[0];

endmodule

// File: src/cv_port_mux.sv
`include "cv_ctrl_consts.svh"

module cv_port_mux (
    input  cv_ctrl_pkg::port_in_t    port_in_i,
    input  cv_ctrl_pkg::keypad_t     keypad_i,
    input  logic [`CV_KEY_BITS-1:0]  ps2_joy_i,
    output logic [3:0]               p1_4_o,
    output logic                     p6_o
);
    import cv_ctrl_pkg::*;

    port_mode_e mode;

    // Pin 5 low selects the keypad, pin 8 low selects the joystick
    always_comb begin
        if (!port_in_i.sel_p5 && port_in_i.sel_p8) begin
            mode = MODE_KEYPAD;
        end else if (port_in_i.sel_p5 && !port_in_i.sel_p8) begin
            mode = MODE_JOYSTICK;
        end else begin
            mode = MODE_IDLE;
        end
    end

    // -----------------------------------------------------------------------
    // Pin levels per mode, all active low
    // -----------------------------------------------------------------------
    always_comb begin
        case (mode)
            MODE_KEYPAD: begin
                p1_4_o = keypad_i.p1_4;
                p6_o   = keypad_i.p6 & ~port_in_i.joy[`CV_JOY_FIRE2];
            end
            MODE_JOYSTICK: begin
                // Host joystick and PS/2 flags are ORed
                p1_4_o[3] = ~(ps2_joy_i[`CV_PS2J_UP] | port_in_i.joy[`CV_JOY_UP]);
                p1_4_o[2] = ~(ps2_joy_i[`CV_PS2J_DOWN] | port_in_i.joy[`CV_JOY_DOWN]);
                p1_4_o[1] = ~(ps2_joy_i[`CV_PS2J_LEFT] | port_in_i.joy[`CV_JOY_LEFT]);
                p1_4_o[0] = ~(ps2_joy_i[`CV_PS2J_RIGHT] | port_in_i.joy[`CV_JOY_RIGHT]);
                p6_o      = ~(ps2_joy_i[`CV_PS2J_FIRE] | port_in_i.joy[`CV_JOY_FIRE1]);
            end
            default: begin
                p1_4_o = 4'b1111;
                p6_o   = 1'b1;
            end
        endcase
    end

endmodule

// File: src/cv_spinner.sv
`include "cv_ctrl_consts.svh"

module cv_spinner (
    input  logic                  clk_sys_i,
    input  logic                  reset_i,
    input  cv_ctrl_pkg::port_in_t port_in_i,
    input  logic                  spinner_en_i,
    input  logic                  spinner_tick_i,
    output logic                  p7_o,
    output logic                  p9_o
);

    // Quadrature phase, bit 1 drives pin 7 and bit 0 drives pin 9
    logic [1:0] phase;
    logic       left;
    logic       right;

    assign left  = port_in_i.joy[`CV_JOY_LEFT];
    assign right = port_in_i.joy[`CV_JOY_RIGHT];

    // -----------------------------------------------------------------------
    // Gray-code stepping, one step per tick
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_sys_i) begin
        if (reset_i || !spinner_en_i) begin
            phase <= 2'b11;
        end else if (spinner_tick_i) begin
            if (left) begin
                // 00 -> 01 -> 11 -> 10
                case (phase)
                    2'b00:   phase <= 2'b01;
                    2'b01:   phase <= 2'b11;
                    2'b11:   phase <= 2'b10;
                    default: phase <= 2'b00;
                endcase
            end else if (right) begin
                // Opposite direction
                case (phase)
                    2'b00:   phase <= 2'b10;
                    2'b10:   phase <= 2'b11;
                    2'b11:   phase <= 2'b01;
                    default: phase <= 2'b00;
                endcase
            end
        end
    end

    assign p7_o = phase[1];
    assign p9_o = phase[0];

endmodule

// File: test/tb_cv_controller.sv
`include "cv_ctrl_consts.svh"

module tb_cv_controller;
    timeunit 1ns;
    timeprecision 1ps;

    import cv_ctrl_pkg::*;

    localparam int clk_period    = 20;
    localparam int spin_bits     = 4;
    localparam int spin_period   = 1 << spin_bits;
    localparam int n_rand        = 40;
    localparam int window_cycles = 64;
    localparam int run_cycles    = 8 + 16 + 4 * n_rand + 4 * (window_cycles + 8) + 6 * 4;
    localparam int margin_cycles = 100;

    // Key flag bits in priority order, and the pin 1 to 4 pattern of each
    localparam logic [0:11][3:0] prio_bit = {4'd13, 4'd7, 4'd12, 4'd2, 4'd3, 4'd14,
                                             4'd5, 4'd1, 4'd11, 4'd10, 4'd9, 4'd6};
    localparam logic [0:11][3:0] prio_pat = {4'b1110, 4'b1101, 4'b0110, 4'b0001,
                                             4'b1001, 4'b0111, 4'b1100, 4'b1000,
                                             4'b1011, 4'b0011, 4'b1010, 4'b0101};

    logic                       clk_sys = 1'b0;
    logic                       reset;
    logic [`CV_JOY_BITS-1:0]    joy0_i;
    logic [`CV_JOY_BITS-1:0]    joy1_i;
    logic [`CV_KEY_BITS-1:0]    ps2_keys_i;
    logic [`CV_KEY_BITS-1:0]    ps2_joy_i;
    logic [`CV_PORTS-1:0]       sel_p5_i;
    logic [`CV_PORTS-1:0]       sel_p8_i;
    logic                       joyswap_i;
    logic                       spinner_en_i;
    ctrl_pins_t [`CV_PORTS-1:0] ports_o;

    // Model of the registered state, one edge behind the stimulus
    port_in_t [`CV_PORTS-1:0]   m_in;
    logic [`CV_KEY_BITS-1:0]    m_keys;
    logic [`CV_KEY_BITS-1:0]    m_pjoy;
    logic                       m_en;
    logic                       m_tick;
    int                         m_cnt;
    logic [1:0]                 m_phase [`CV_PORTS];

    logic [31:0] rng = 32'd86;
    logic        check_on = 1'b0;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          err_start = 0;
    int          spin_changes [`CV_PORTS];
    logic [1:0]  last_spin [`CV_PORTS];

    always #(clk_period / 2) clk_sys = ~clk_sys;

    cv_controller_top #(
        .spin_div_bits (spin_bits)
    ) i_dut (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .joy0_i       (joy0_i),
        .joy1_i       (joy1_i),
        .ps2_keys_i   (ps2_keys_i),
        .ps2_joy_i    (ps2_joy_i),
        .sel_p5_i     (sel_p5_i),
        .sel_p8_i     (sel_p8_i),
        .joyswap_i    (joyswap_i),
        .spinner_en_i (spinner_en_i),
        .ports_o      (ports_o)
    );

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Left walks the sequence forward, right walks it backward
    function automatic logic [1:0] spin_step(input logic [1:0] ph, input logic en,
                                             input logic tick, input logic [7:0] joy);
        logic [0:3][1:0] seq;
        int              idx;
        seq = {2'b00, 2'b01, 2'b11, 2'b10};
        idx = 0;
        for (int i = 0; i < 4; i++) begin
            if (seq[i] == ph) begin
                idx = i;
            end
        end
        if (!en) begin
            return 2'b11;
        end
        if (!tick) begin
            return ph;
        end
        if (joy[`CV_JOY_LEFT]) begin
            return seq[(idx + 1) % 4];
        end
        if (joy[`CV_JOY_RIGHT]) begin
            return seq[(idx + 3) % 4];
        end
        return ph;
    endfunction

    function automatic ctrl_pins_t ref_pins(input logic [7:0] joy, input logic p5,
                                            input logic p8, input logic [15:0] keys,
                                            input logic [15:0] pjoy, input logic [1:0] phase);
        ctrl_pins_t pins;
        logic [3:0] pat;
        pins = '1;
        pat  = 4'b1111;
        // Lowest priority first so the highest pressed key is left standing
        for (int i = 11; i >= 0; i--) begin
            if (keys[prio_bit[i]]) begin
                pat = prio_pat[i];
            end
        end
        if (!p5 && p8) begin
            {pins.p1, pins.p2, pins.p3, pins.p4} = pat;
            pins.p6 = !(keys[0] || joy[`CV_JOY_FIRE2]);
        end else if (p5 && !p8) begin
            pins.p1 = !(pjoy[`CV_PS2J_UP] || joy[`CV_JOY_UP]);
            pins.p2 = !(pjoy[`CV_PS2J_DOWN] || joy[`CV_JOY_DOWN]);
            pins.p3 = !(pjoy[`CV_PS2J_LEFT] || joy[`CV_JOY_LEFT]);
            pins.p4 = !(pjoy[`CV_PS2J_RIGHT] || joy[`CV_JOY_RIGHT]);
            pins.p6 = !(pjoy[`CV_PS2J_FIRE] || joy[`CV_JOY_FIRE1]);
        end
        pins.p7 = phase[1];
        pins.p9 = phase[0];
        return pins;
    endfunction

    always @(posedge clk_sys) begin
        if (reset) begin
            for (int p = 0; p < `CV_PORTS; p++) begin
                m_in[p].joy    = '0;
                m_in[p].sel_p5 = 1'b1;
                m_in[p].sel_p8 = 1'b1;
                m_phase[p]     = 2'b11;
            end
            m_keys = '0;
            m_pjoy = '0;
            m_en   = 1'b0;
            m_tick = 1'b0;
            m_cnt  = 0;
        end else begin
            // Phase steps on the values held since the last edge
            for (int p = 0; p < `CV_PORTS; p++) begin
                m_phase[p] = spin_step(m_phase[p], m_en, m_tick, m_in[p].joy);
                m_in[p].sel_p5 = sel_p5_i[p];
                m_in[p].sel_p8 = sel_p8_i[p];
            end
            m_tick = (m_cnt == 0);
            m_cnt  = (m_cnt + 1) % spin_period;
            m_in[0].joy = joyswap_i ? joy1_i : joy0_i;
            m_in[1].joy = joyswap_i ? joy0_i : joy1_i;
            m_keys = ps2_keys_i;
            m_pjoy = ps2_joy_i;
            m_en   = spinner_en_i;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_sys) begin : compare
        ctrl_pins_t exp_pins;
        if (check_on) begin
            for (int p = 0; p < `CV_PORTS; p++) begin
                exp_pins = ref_pins(m_in[p].joy, m_in[p].sel_p5, m_in[p].sel_p8,
                                    m_keys, m_pjoy, m_phase[p]);
                check_count++;
                if (ports_o[p] !== exp_pins) begin
                    $display("Fail at %0d ns: port %0d pins %b, expected %b",
                             $time, p, ports_o[p], exp_pins);
                    err_count++;
                end
                if ({ports_o[p].p7, ports_o[p].p9} != last_spin[p]) begin
                    spin_changes[p]++;
                end
                last_spin[p] = {ports_o[p].p7, ports_o[p].p9};
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic drive_random(input logic [1:0] p5, input logic [1:0] p8);
        @(negedge clk_sys);
        rng        = xorshift(rng);
        joy0_i     = rng[7:0];
        joy1_i     = rng[15:8];
        ps2_joy_i  = rng[31:16];
        rng        = xorshift(rng);
        ps2_keys_i = rng[15:0] & rng[31:16];
        sel_p5_i   = p5;
        sel_p8_i   = p8;
    endtask

    task automatic begin_test();
        @(posedge clk_sys);
        err_start = err_count;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk_sys);
        test_count++;
        $display("Test %s finished with %0d errors", name, err_count - err_start);
    endtask

    task automatic spin_window(input logic en, input logic [7:0] dir, input int steps);
        @(negedge clk_sys);
        spinner_en_i = en;
        joy0_i       = dir;
        joy1_i       = dir;
        repeat (4) @(negedge clk_sys);
        @(posedge clk_sys);
        spin_changes[0] = 0;
        spin_changes[1] = 0;
        repeat (window_cycles) @(negedge clk_sys);
        @(posedge clk_sys);
        for (int p = 0; p < `CV_PORTS; p++) begin
            if (spin_changes[p] != steps) begin
                $display("Fail at %0d ns: port %0d spinner stepped %0d times, expected %0d",
                         $time, p, spin_changes[p], steps);
                err_count++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic idle_test();
        logic [1:0] idle_sel;
        begin_test();
        @(negedge clk_sys);
        if (ports_o !== '1) begin
            $display("Fail at %0d ns: pins %b after reset, expected all high", $time, ports_o);
            err_count++;
        end
        // Same level on pin 5 and pin 8 of a port
        for (int i = 0; i < n_rand; i++) begin
            rng      = xorshift(rng);
            idle_sel = rng[1:0];
            drive_random(idle_sel, idle_sel);
        end
        end_test("idle");
    endtask

    task automatic keypad_test();
        begin_test();
        for (int b = 0; b < `CV_KEY_BITS; b++) begin
            @(negedge clk_sys);
            sel_p5_i   = 2'b00;
            sel_p8_i   = 2'b11;
            joy0_i     = '0;
            joy1_i     = '0;
            ps2_keys_i = 16'd1 << b;
        end
        for (int i = 0; i < n_rand; i++) begin
            drive_random(2'b00, 2'b11);
        end
        end_test("keypad");
    endtask

    task automatic joystick_test();
        begin_test();
        for (int i = 0; i < n_rand; i++) begin
            // Second half mixes port 1 keypad with port 2 joystick
            if (i < n_rand / 2) begin
                drive_random(2'b11, 2'b00);
            end else begin
                drive_random(2'b10, 2'b01);
            end
        end
        end_test("joystick");
    endtask

    task automatic swap_test();
        begin_test();
        for (int i = 0; i < n_rand; i++) begin
            drive_random(2'b11, 2'b00);
            ps2_joy_i = '0;
            joyswap_i = (i < n_rand / 2);
        end
        @(negedge clk_sys);
        joyswap_i = 1'b0;
        end_test("swap");
    endtask

    task automatic spinner_test();
        logic [7:0] left_dir;
        logic [7:0] right_dir;
        left_dir  = 8'h01 << `CV_JOY_LEFT;
        right_dir = 8'h01 << `CV_JOY_RIGHT;
        begin_test();
        @(negedge clk_sys);
        sel_p5_i   = 2'b11;
        sel_p8_i   = 2'b00;
        ps2_joy_i  = '0;
        ps2_keys_i = '0;
        joyswap_i  = 1'b0;
        spin_window(1'b0, left_dir, 0);
        spin_window(1'b1, left_dir, window_cycles / spin_period);
        spin_window(1'b1, right_dir, window_cycles / spin_period);
        spin_window(1'b1, left_dir | right_dir, window_cycles / spin_period);
        @(negedge clk_sys);
        spinner_en_i = 1'b0;
        joy0_i       = '0;
        joy1_i       = '0;
        end_test("spinner");
    endtask

    initial begin
        joy0_i       = '0;
        joy1_i       = '0;
        ps2_keys_i   = '0;
        ps2_joy_i    = '0;
        sel_p5_i     = '1;
        sel_p8_i     = '1;
        joyswap_i    = 1'b0;
        spinner_en_i = 1'b0;
        reset        = 1'b1;
        @(posedge clk_sys);
        check_on = 1'b1;
        repeat (7) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;

        idle_test();
        keypad_test();
        joystick_test();
        swap_test();
        spinner_test();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #((run_cycles + margin_cycles) * clk_period);
        $display("Timeout: the tests did not complete within %0d clock cycles",
                 run_cycles + margin_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
src/cv_ctrl_pkg.sv
src/cv_input_stage.sv
src/cv_keypad_encoder.sv
src/cv_spinner.sv
src/cv_port_mux.sv
src/cv_controller_top.sv
test/tb_cv_controller.sv
